// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_reorder_output_queues
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
BIN       ?= $(OBJ_DIR)/V$(TOP)
LOG       ?= sim.log
PASS_MSG  ?= Regression passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SOURCES   ?= $(shell grep -v '^+' $(FILELIST))

.PHONY: all run check clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

# Judge an existing log without rerunning
check:
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== compile.f ====
design/oq_pkg.sv
design/stream_fifo.sv
design/packet_distributor.sv
design/output_queue.sv
design/reorder_output_queues.sv
dv/tb_reorder_output_queues.sv

// ==== design/oq_pkg.sv ====
// Shared widths, buffer sizing and state codes for the output-queue block
`default_nettype none

package oq_pkg;

   // Metadata word layout, timestamp above the kept tuser bits
   localparam int TIMESTAMP_WIDTH = 64;
   localparam int USER_KEEP_WIDTH = 64;

   // Largest packet a queue must still absorb once it accepts one
   localparam int MAX_PACKET_BYTES = 1600;

   localparam int META_DEPTH_BITS = 5;   // 32 stored packets per queue
   localparam int IN_DEPTH_BITS   = 2;   // Small skid buffer at the input

   // Distributor FSM
   localparam logic [1:0] DIST_IDLE  = 2'd0;
   localparam logic [1:0] DIST_WRITE = 2'd1;   // Copying a packet
   localparam logic [1:0] DIST_DROP  = 2'd2;   // Discarding a packet

   // Metadata reader FSM
   localparam logic META_WAIT_HEADER = 1'b0;
   localparam logic META_WAIT_EOP    = 1'b1;

endpackage

`default_nettype wire

// ==== design/output_queue.sv ====
// One output queue with data FIFO, metadata FIFO and metadata read FSM
`timescale 1ns/10ps
`default_nettype none

module output_queue #(
   parameter int DATA_WIDTH   = 64,
   parameter int USER_WIDTH   = 128,
   parameter int BUFFER_WORDS = 512
) (
   input  wire                          axi_aclk,
   input  wire                          axi_resetn,
   input  wire [DATA_WIDTH+DATA_WIDTH/8:0] wr_word,
   input  wire [USER_WIDTH-1:0]         wr_meta,
   input  wire                          data_wr_en,
   input  wire                          meta_wr_en,
   input  wire                          m_axis_tready,
   output wire [DATA_WIDTH-1:0]         m_axis_tdata,
   output wire [DATA_WIDTH/8-1:0]       m_axis_tstrb,
   output wire [USER_WIDTH-1:0]         m_axis_tuser,
   output wire                          m_axis_tlast,
   output wire                          m_axis_tvalid,
   output wire                          queue_full
);

   localparam int BYTES_PER_WORD = DATA_WIDTH / 8;
   localparam int PACKET_WORDS   =
      (oq_pkg::MAX_PACKET_BYTES + BYTES_PER_WORD - 1) / BYTES_PER_WORD;
   // Room for a maximum packet; small buffers keep half free instead
   localparam int DATA_THRESHOLD = (BUFFER_WORDS > PACKET_WORDS) ?
                                   BUFFER_WORDS - PACKET_WORDS : BUFFER_WORDS / 2;

   logic data_empty;
   logic data_prog_full;
   logic data_rd_en;
   logic meta_empty;
   logic meta_nearly_full;
   logic meta_rd_en;
   logic meta_state;
   logic meta_state_next;

   stream_fifo #(
      .WIDTH               (DATA_WIDTH + DATA_WIDTH/8 + 1),
      .DEPTH_BITS          ($clog2(BUFFER_WORDS)),
      .PROG_FULL_THRESHOLD (DATA_THRESHOLD)
   ) data_fifo (
      .axi_aclk    (axi_aclk),
      .axi_resetn  (axi_resetn),
      .din         (wr_word),
      .wr_en       (data_wr_en),
      .rd_en       (data_rd_en),
      .dout        ({m_axis_tlast, m_axis_tstrb, m_axis_tdata}),
      .empty       (data_empty),
      .nearly_full (),
      .prog_full   (data_prog_full)
   );

   // Head is the metadata of the packet whose first word is next out
   stream_fifo #(
      .WIDTH      (USER_WIDTH),
      .DEPTH_BITS (oq_pkg::META_DEPTH_BITS)
   ) meta_fifo (
      .axi_aclk    (axi_aclk),
      .axi_resetn  (axi_resetn),
      .din         (wr_meta),
      .wr_en       (meta_wr_en),
      .rd_en       (meta_rd_en),
      .dout        (m_axis_tuser),
      .empty       (meta_empty),
      .nearly_full (meta_nearly_full),
      .prog_full   ()
   );

   assign m_axis_tvalid = !data_empty;
   assign data_rd_en    = m_axis_tvalid & m_axis_tready;
   assign queue_full    = data_prog_full | meta_nearly_full;

   always_comb begin
      meta_state_next = meta_state;
      meta_rd_en      = 1'b0;
      case (meta_state)
         oq_pkg::META_WAIT_HEADER: begin
            if (data_rd_en) begin
               meta_rd_en = 1'b1;   // Pop on the first word
               if (!m_axis_tlast) begin
                  meta_state_next = oq_pkg::META_WAIT_EOP;   // Single-word packets stay
               end
            end
         end
         oq_pkg::META_WAIT_EOP: begin
            if (data_rd_en && m_axis_tlast) begin
               meta_state_next = oq_pkg::META_WAIT_HEADER;
            end
         end
      endcase
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         meta_state <= oq_pkg::META_WAIT_HEADER;
      end else begin
         meta_state <= meta_state_next;
      end
   end

   // Distributor writes metadata with the first data word
   a_meta_present: assert property (
      @(posedge axi_aclk) disable iff (!axi_resetn)
      (data_rd_en && meta_state == oq_pkg::META_WAIT_HEADER) |-> !meta_empty
   ) else $error("packet leaves without metadata");

endmodule

`default_nettype wire

// ==== design/packet_distributor.sv ====
// Round-robin packet distributor with drop decision, timestamp and drop counters
`timescale 1ns/10ps
`default_nettype none

module packet_distributor #(
   parameter int DATA_WIDTH = 64,
   parameter int USER_WIDTH = 128,
   parameter int NUM_QUEUES = 5
) (
   input  wire                              axi_aclk,
   input  wire                              axi_resetn,
   input  wire                              in_empty,
   input  wire [DATA_WIDTH-1:0]             in_tdata,
   input  wire [DATA_WIDTH/8-1:0]           in_tstrb,
   input  wire [USER_WIDTH-1:0]             in_tuser,
   input  wire                              in_tlast,
   input  wire [NUM_QUEUES-1:0]             queue_full,
   input  wire [31:0]                       last_queue,
   input  wire                              clear_drops,
   output logic                             in_rd_en,
   output logic [DATA_WIDTH+DATA_WIDTH/8:0] wr_word,
   output logic [USER_WIDTH-1:0]            wr_meta,
   output logic [NUM_QUEUES-1:0]            data_wr_en,
   output logic [NUM_QUEUES-1:0]            meta_wr_en,
   output logic [32*NUM_QUEUES-1:0]         drop_counts
);

   logic [1:0]                          state;
   logic [1:0]                          state_next;
   logic [NUM_QUEUES-1:0]               cur_queue;   // One-hot target queue
   logic [NUM_QUEUES-1:0]               cur_queue_next;
   logic [NUM_QUEUES-1:0]               next_in_rotation;
   logic [NUM_QUEUES-1:0]               shifted;
   logic                                wrap;
   logic                                first_word;
   logic                                first_word_next;
   logic [NUM_QUEUES-1:0]               full_q;      // Queue status, one cycle old
   logic [NUM_QUEUES-1:0]               drop_inc;
   logic [oq_pkg::TIMESTAMP_WIDTH-1:0]  timestamp;

   // Same word goes to every queue, the enables pick one
   assign wr_word = {in_tlast, in_tstrb, in_tdata};
   assign wr_meta = {timestamp, in_tuser[oq_pkg::USER_KEEP_WIDTH-1:0]};

   // Wrap after the last active queue or the last physical one
   assign shifted          = cur_queue >> last_queue;
   assign wrap             = cur_queue[NUM_QUEUES-1] | shifted[0];
   assign next_in_rotation = wrap ? NUM_QUEUES'(1) : (cur_queue << 1);

   always_comb begin
      state_next      = state;
      cur_queue_next  = cur_queue;
      first_word_next = first_word;
      in_rd_en        = 1'b0;
      data_wr_en      = '0;
      meta_wr_en      = '0;
      drop_inc        = '0;

      case (state)
         oq_pkg::DIST_IDLE: begin
            if (!in_empty) begin
               // Target must hold a maximum-size packet, else drop it whole
               if (|(full_q & cur_queue)) begin
                  state_next = oq_pkg::DIST_DROP;
                  drop_inc   = cur_queue;
               end else begin
                  state_next      = oq_pkg::DIST_WRITE;
                  first_word_next = 1'b1;
               end
            end
         end

         oq_pkg::DIST_WRITE: begin
            if (!in_empty) begin
               in_rd_en        = 1'b1;
               data_wr_en      = cur_queue;
               first_word_next = 1'b0;
               if (first_word) begin
                  meta_wr_en = cur_queue;   // One metadata word per packet
               end
               if (in_tlast) begin
                  cur_queue_next = next_in_rotation;
                  state_next     = oq_pkg::DIST_IDLE;
               end
            end
         end

         oq_pkg::DIST_DROP: begin
            if (!in_empty) begin
               in_rd_en = 1'b1;   // Pop and discard
               if (in_tlast) begin
                  cur_queue_next = next_in_rotation;   // Rotation still advances
                  state_next     = oq_pkg::DIST_IDLE;
               end
            end
         end

         default: state_next = oq_pkg::DIST_IDLE;
      endcase
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         state       <= oq_pkg::DIST_IDLE;
         cur_queue   <= NUM_QUEUES'(1);
         first_word  <= 1'b0;
         full_q      <= '0;
         timestamp   <= '0;
         drop_counts <= '0;
      end else begin
         state      <= state_next;
         cur_queue  <= cur_queue_next;
         first_word <= first_word_next;
         full_q     <= queue_full;
         timestamp  <= timestamp + 1'b1;   // Free running

         for (int q = 0; q < NUM_QUEUES; q++) begin
            if (clear_drops) begin
               drop_counts[q*32 +: 32] <= '0;
            end else if (drop_inc[q]) begin
               drop_counts[q*32 +: 32] <= drop_counts[q*32 +: 32] + 32'd1;
            end
         end
      end
   end

   a_pointer_onehot: assert property (
      @(posedge axi_aclk) disable iff (!axi_resetn)
      $onehot(cur_queue)
   ) else $error("queue pointer lost its one-hot encoding");

endmodule

`default_nettype wire

// ==== design/reorder_output_queues.sv ====
// Top level with input FIFO, packet distributor and the output queues
`timescale 1ns/10ps
`default_nettype none

module reorder_output_queues #(
   parameter int DATA_WIDTH   = 64,
   parameter int USER_WIDTH   = 128,
   parameter int NUM_QUEUES   = 5,
   parameter int BUFFER_WORDS = 512
) (
   input  wire                               axi_aclk,
   input  wire                               axi_resetn,
   input  wire [DATA_WIDTH-1:0]              s_axis_tdata,
   input  wire [DATA_WIDTH/8-1:0]            s_axis_tstrb,
   input  wire [USER_WIDTH-1:0]              s_axis_tuser,
   input  wire                               s_axis_tlast,
   input  wire                               s_axis_tvalid,
   output wire                               s_axis_tready,
   output wire [NUM_QUEUES*DATA_WIDTH-1:0]   m_axis_tdata,
   output wire [NUM_QUEUES*DATA_WIDTH/8-1:0] m_axis_tstrb,
   output wire [NUM_QUEUES*USER_WIDTH-1:0]   m_axis_tuser,
   output wire [NUM_QUEUES-1:0]              m_axis_tlast,
   output wire [NUM_QUEUES-1:0]              m_axis_tvalid,
   input  wire [NUM_QUEUES-1:0]              m_axis_tready,
   input  wire [31:0]                        last_queue,
   input  wire                               clear_drops,
   output wire [32*NUM_QUEUES-1:0]           drop_counts
);

   localparam int STRB_WIDTH = DATA_WIDTH / 8;

   wire                          in_nearly_full;
   wire                          in_empty;
   wire                          in_rd_en;
   wire [DATA_WIDTH-1:0]         in_tdata;
   wire [STRB_WIDTH-1:0]         in_tstrb;
   wire [USER_WIDTH-1:0]         in_tuser;
   wire                          in_tlast;
   wire [DATA_WIDTH+STRB_WIDTH:0] wr_word;   // {tlast, tstrb, tdata}
   wire [USER_WIDTH-1:0]         wr_meta;
   wire [NUM_QUEUES-1:0]         data_wr_en;
   wire [NUM_QUEUES-1:0]         meta_wr_en;
   wire [NUM_QUEUES-1:0]         queue_full;

   assign s_axis_tready = !in_nearly_full;

   stream_fifo #(
      .WIDTH      (DATA_WIDTH + STRB_WIDTH + USER_WIDTH + 1),
      .DEPTH_BITS (oq_pkg::IN_DEPTH_BITS)
   ) input_fifo (
      .axi_aclk    (axi_aclk),
      .axi_resetn  (axi_resetn),
      .din         ({s_axis_tlast, s_axis_tuser, s_axis_tstrb, s_axis_tdata}),
      .wr_en       (s_axis_tvalid & s_axis_tready),
      .rd_en       (in_rd_en),
      .dout        ({in_tlast, in_tuser, in_tstrb, in_tdata}),
      .empty       (in_empty),
      .nearly_full (in_nearly_full),
      .prog_full   ()
   );

   packet_distributor #(
      .DATA_WIDTH (DATA_WIDTH),
      .USER_WIDTH (USER_WIDTH),
      .NUM_QUEUES (NUM_QUEUES)
   ) distributor (
      .axi_aclk    (axi_aclk),
      .axi_resetn  (axi_resetn),
      .in_empty    (in_empty),
      .in_tdata    (in_tdata),
      .in_tstrb    (in_tstrb),
      .in_tuser    (in_tuser),
      .in_tlast    (in_tlast),
      .queue_full  (queue_full),
      .last_queue  (last_queue),
      .clear_drops (clear_drops),
      .in_rd_en    (in_rd_en),
      .wr_word     (wr_word),
      .wr_meta     (wr_meta),
      .data_wr_en  (data_wr_en),
      .meta_wr_en  (meta_wr_en),
      .drop_counts (drop_counts)
   );

   for (genvar q = 0; q < NUM_QUEUES; q++) begin : g_queue
      output_queue #(
         .DATA_WIDTH   (DATA_WIDTH),
         .USER_WIDTH   (USER_WIDTH),
         .BUFFER_WORDS (BUFFER_WORDS)
      ) queue (
         .axi_aclk      (axi_aclk),
         .axi_resetn    (axi_resetn),
         .wr_word       (wr_word),
         .wr_meta       (wr_meta),
         .data_wr_en    (data_wr_en[q]),
         .meta_wr_en    (meta_wr_en[q]),
         .m_axis_tready (m_axis_tready[q]),
         .m_axis_tdata  (m_axis_tdata[q*DATA_WIDTH +: DATA_WIDTH]),
         .m_axis_tstrb  (m_axis_tstrb[q*STRB_WIDTH +: STRB_WIDTH]),
         .m_axis_tuser  (m_axis_tuser[q*USER_WIDTH +: USER_WIDTH]),
         .m_axis_tlast  (m_axis_tlast[q]),
         .m_axis_tvalid (m_axis_tvalid[q]),
         .queue_full    (queue_full[q])
      );
   end

endmodule

`default_nettype wire

// ==== design/stream_fifo.sv ====
// Fall-through FIFO with empty, nearly_full and programmable-full flags
`timescale 1ns/10ps
`default_nettype none

module stream_fifo #(
   parameter int WIDTH               = 8,
   parameter int DEPTH_BITS          = 4,
   parameter int PROG_FULL_THRESHOLD = (1 << DEPTH_BITS) - 1
) (
   input  wire              axi_aclk,
   input  wire              axi_resetn,
   input  wire [WIDTH-1:0]  din,
   input  wire              wr_en,
   input  wire              rd_en,
   output logic [WIDTH-1:0] dout,
   output logic             empty,
   output logic             nearly_full,
   output logic             prog_full
);

   localparam int DEPTH = 1 << DEPTH_BITS;

   // Fill levels compared against the occupancy counter
   localparam logic [DEPTH_BITS:0] FULL_LEVEL   = (DEPTH_BITS+1)'(DEPTH);
   localparam logic [DEPTH_BITS:0] NEARLY_LEVEL = (DEPTH_BITS+1)'(DEPTH - 1);
   localparam logic [DEPTH_BITS:0] PROG_LEVEL   = (DEPTH_BITS+1)'(PROG_FULL_THRESHOLD);

   logic [WIDTH-1:0]      mem [DEPTH];
   logic [DEPTH_BITS-1:0] wr_ptr;
   logic [DEPTH_BITS-1:0] rd_ptr;
   logic [DEPTH_BITS:0]   count;   // One bit wider to tell full from empty
   logic                  full;

   always_ff @(posedge axi_aclk) begin
      if (wr_en) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // Idle or simultaneous push and pop
         endcase
      end
   end

   // Head word is always visible
   assign dout = mem[rd_ptr];

   assign empty       = (count == '0);
   assign full        = (count == FULL_LEVEL);
   assign nearly_full = (count >= NEARLY_LEVEL);   // One free entry left
   assign prog_full   = (count >= PROG_LEVEL);

   // A push into a full FIFO is only safe with a pop in the same cycle
   a_no_overflow: assert property (
      @(posedge axi_aclk) disable iff (!axi_resetn)
      wr_en |-> (!full || rd_en)
   ) else $error("stream_fifo write while full");

   a_no_underflow: assert property (
      @(posedge axi_aclk) disable iff (!axi_resetn)
      rd_en |-> !empty
   ) else $error("stream_fifo read while empty");

endmodule

`default_nettype wire

// ==== dv/tb_reorder_output_queues.sv ====
// Testbench for reorder_output_queues with random packets, a per-queue packet model and checks
`timescale 1ns/10ps
`default_nettype none

module tb_reorder_output_queues;

   localparam int DATA_WIDTH   = 64;
   localparam int USER_WIDTH   = 128;
   localparam int NUM_QUEUES   = 5;
   localparam int BUFFER_WORDS = 64;
   localparam int STRB_WIDTH   = DATA_WIDTH / 8;
   localparam int WORD_WIDTH   = DATA_WIDTH + STRB_WIDTH + 1;   // {tlast, tstrb, tdata}
   localparam int KEEP_WIDTH   = 64;   // Low tuser bits carried through

   logic                             axi_aclk;
   logic                             axi_resetn;
   logic [DATA_WIDTH-1:0]            s_axis_tdata;
   logic [STRB_WIDTH-1:0]            s_axis_tstrb;
   logic [USER_WIDTH-1:0]            s_axis_tuser;
   logic                             s_axis_tlast;
   logic                             s_axis_tvalid;
   wire                              s_axis_tready;
   wire  [NUM_QUEUES*DATA_WIDTH-1:0] m_axis_tdata;
   wire  [NUM_QUEUES*STRB_WIDTH-1:0] m_axis_tstrb;
   wire  [NUM_QUEUES*USER_WIDTH-1:0] m_axis_tuser;
   wire  [NUM_QUEUES-1:0]            m_axis_tlast;
   wire  [NUM_QUEUES-1:0]            m_axis_tvalid;
   logic [NUM_QUEUES-1:0]            m_axis_tready;
   logic [31:0]                      last_queue;
   logic                             clear_drops;
   wire  [32*NUM_QUEUES-1:0]         drop_counts;

   // Expected packets per queue, words kept flat with a length per packet
   logic [WORD_WIDTH-1:0] exp_words [NUM_QUEUES][$];
   int                    exp_len   [NUM_QUEUES][$];
   logic [KEEP_WIDTH-1:0] exp_user  [NUM_QUEUES][$];
   logic [WORD_WIDTH-1:0] rx_words  [NUM_QUEUES][$];   // Packet being received
   logic [KEEP_WIDTH-1:0] rx_user     [NUM_QUEUES];
   logic [63:0]           last_ts     [NUM_QUEUES];
   logic                  ts_seen     [NUM_QUEUES];
   logic                  valid_seen  [NUM_QUEUES];
   int                    assigned    [NUM_QUEUES];
   int                    delivered   [NUM_QUEUES];
   int                    model_drops [NUM_QUEUES];

   integer seed = 32'h559f;
   int     rot_ptr;
   int     words_sent = 0;
   int     cycle_count = 0;
   int     errors = 0;
   int     tests_ok = 0;
   int     tests_bad = 0;
   int     errors_at_start;
   string  cur_test;

   reorder_output_queues #(
      .DATA_WIDTH   (DATA_WIDTH),
      .USER_WIDTH   (USER_WIDTH),
      .NUM_QUEUES   (NUM_QUEUES),
      .BUFFER_WORDS (BUFFER_WORDS)
   ) DUT (
      .axi_aclk      (axi_aclk),
      .axi_resetn    (axi_resetn),
      .s_axis_tdata  (s_axis_tdata),
      .s_axis_tstrb  (s_axis_tstrb),
      .s_axis_tuser  (s_axis_tuser),
      .s_axis_tlast  (s_axis_tlast),
      .s_axis_tvalid (s_axis_tvalid),
      .s_axis_tready (s_axis_tready),
      .m_axis_tdata  (m_axis_tdata),
      .m_axis_tstrb  (m_axis_tstrb),
      .m_axis_tuser  (m_axis_tuser),
      .m_axis_tlast  (m_axis_tlast),
      .m_axis_tvalid (m_axis_tvalid),
      .m_axis_tready (m_axis_tready),
      .last_queue    (last_queue),
      .clear_drops   (clear_drops),
      .drop_counts   (drop_counts)
   );

   initial axi_aclk = 1'b0;
   always #5 axi_aclk = ~axi_aclk;

   // Limit grows with the traffic, so a stall stops the run
   always @(posedge axi_aclk) begin
      cycle_count++;
      if (cycle_count > 2 * words_sent + 2000) begin
         $display("ERROR: timeout after %0d cycles, %0d words sent", cycle_count, words_sent);
         $display("Regression failed");
         $finish;
      end
   end

   task automatic compare_value(input string what, input longint expected, input longint actual);
      if (expected != actual) begin
         errors++;
         $display("CHECK FAILED %s: %s expected %0d, actual %0d", cur_test, what, expected, actual);
      end
   endtask

   task automatic remove_head(input int q);
      for (int i = 0; i < exp_len[q][0]; i++) begin
         exp_words[q].delete(0);
      end
      exp_len[q].delete(0);
      exp_user[q].delete(0);
   endtask

   function automatic bit head_matches(input int q);
      bit same;
      same = (exp_len[q][0] == rx_words[q].size());
      for (int i = 0; i < rx_words[q].size(); i++) begin
         if (same && exp_words[q][i] != rx_words[q][i]) begin
            same = 1'b0;
         end
      end
      return same;
   endfunction

   // Packets ahead of the delivered one never came out, so they were dropped
   task automatic match_packet(input int q);
      bit found;
      found = 1'b0;
      while (!found && exp_len[q].size() > 0) begin
         found = head_matches(q);
         if (!found) begin
            remove_head(q);
            model_drops[q]++;
         end
      end
      if (found) begin
         if (exp_user[q][0] != rx_user[q]) begin
            errors++;
            $display("CHECK FAILED %s: tuser low on queue %0d expected %h, actual %h",
                     cur_test, q, exp_user[q][0], rx_user[q]);
         end
         remove_head(q);
         delivered[q]++;
      end else begin
         errors++;
         $display("ERROR: %s: queue %0d delivered a packet that was never sent to it",
                  cur_test, q);
      end
      rx_words[q].delete();
   endtask

   always @(posedge axi_aclk) begin
      logic [63:0] ts;
      if (axi_resetn) begin
         for (int q = 0; q < NUM_QUEUES; q++) begin
            if (m_axis_tvalid[q]) begin
               valid_seen[q] = 1'b1;
            end
            if (m_axis_tvalid[q] && m_axis_tready[q]) begin
               if (rx_words[q].size() == 0) begin   // Metadata is only valid on the first word
                  rx_user[q] = m_axis_tuser[q*USER_WIDTH +: KEEP_WIDTH];
                  ts = m_axis_tuser[q*USER_WIDTH + KEEP_WIDTH +: 64];
                  if (ts_seen[q] && ts <= last_ts[q]) begin
                     errors++;
                     $display("CHECK FAILED %s: timestamp on queue %0d expected above %h, %s %h",
                              cur_test, q, last_ts[q], "actual", ts);
                  end
                  last_ts[q] = ts;
                  ts_seen[q] = 1'b1;
               end
               rx_words[q].push_back({m_axis_tlast[q], m_axis_tstrb[q*STRB_WIDTH +: STRB_WIDTH],
                                      m_axis_tdata[q*DATA_WIDTH +: DATA_WIDTH]});
               if (m_axis_tlast[q]) begin
                  match_packet(q);
               end
            end
         end
      end
   end

   task automatic send_packet(input int len);
      logic [DATA_WIDTH-1:0] data;
      logic [STRB_WIDTH-1:0] strb;
      logic [USER_WIDTH-1:0] user;
      int                    q;
      q = rot_ptr;
      exp_len[q].push_back(len);
      assigned[q]++;
      for (int i = 0; i < len; i++) begin
         user = {$random(seed), $random(seed), $random(seed), $random(seed)};
         data = {$random(seed), $random(seed)};
         strb = STRB_WIDTH'($random(seed));
         if (i == 0) begin
            exp_user[q].push_back(user[KEEP_WIDTH-1:0]);   // Metadata comes from the first word
         end
         exp_words[q].push_back({i == len - 1, strb, data});
         s_axis_tdata  = data;
         s_axis_tstrb  = strb;
         s_axis_tuser  = user;
         s_axis_tlast  = (i == len - 1);
         s_axis_tvalid = 1'b1;
         while (!s_axis_tready) begin
            @(negedge axi_aclk);
         end
         @(negedge axi_aclk);   // Word taken on the rising edge in between
         words_sent++;
      end
      s_axis_tvalid = 1'b0;
      s_axis_tlast  = 1'b0;
      // Wrap after the last active queue or the last physical one
      if (rot_ptr == int'(last_queue) || rot_ptr == NUM_QUEUES - 1) begin
         rot_ptr = 0;
      end else begin
         rot_ptr++;
      end
   endtask

   task automatic send_burst(input int count);
      int gap;
      for (int n = 0; n < count; n++) begin
         send_packet(1 + int'($unsigned($random(seed)) % 8));
         gap = int'($unsigned($random(seed)) % 3);
         repeat (gap) @(negedge axi_aclk);
      end
   endtask

   task automatic wait_idle();
      int quiet;
      quiet = 0;
      while (quiet < 20) begin
         @(negedge axi_aclk);
         if (m_axis_tvalid == '0) begin
            quiet++;
         end else begin
            quiet = 0;
         end
      end
   endtask

   // Whatever is still expected after draining was dropped
   task automatic settle_queues();
      for (int q = 0; q < NUM_QUEUES; q++) begin
         while (exp_len[q].size() > 0) begin
            remove_head(q);
            model_drops[q]++;
         end
      end
   endtask

   task automatic check_clean_run();
      for (int q = 0; q < NUM_QUEUES; q++) begin
         compare_value($sformatf("packets on queue %0d", q), assigned[q], delivered[q]);
         compare_value($sformatf("drop count of queue %0d", q), 0, drop_counts[q*32 +: 32]);
      end
   endtask

   // Queue 2 stalls for a long burst, the rest keep flowing
   task automatic pressure_run(input int count);
      m_axis_tready[2] = 1'b0;
      send_burst(count);
      repeat (50) @(negedge axi_aclk);
      m_axis_tready[2] = 1'b1;
      wait_idle();
      settle_queues();
      for (int q = 0; q < NUM_QUEUES; q++) begin
         compare_value($sformatf("drop count of queue %0d", q), model_drops[q],
                       drop_counts[q*32 +: 32]);
      end
      compare_value("queue 2 delivered plus dropped", assigned[2],
                    delivered[2] + int'(drop_counts[2*32 +: 32]));
      if (model_drops[2] == 0) begin
         errors++;
         $display("ERROR: %s: the stalled queue never dropped a packet", cur_test);
      end
      for (int q = 0; q < NUM_QUEUES; q++) begin
         if (q != 2) begin
            compare_value($sformatf("packets on queue %0d", q), assigned[q], delivered[q]);
         end
      end
   endtask

   task automatic begin_test(input string name);
      cur_test = name;
      errors_at_start = errors;
      for (int q = 0; q < NUM_QUEUES; q++) begin
         assigned[q]   = 0;
         delivered[q]  = 0;
         valid_seen[q] = 1'b0;
      end
   endtask

   task automatic end_test();
      if (errors == errors_at_start) begin
         tests_ok++;
         $display("[ok]     %s", cur_test);
      end else begin
         tests_bad++;
         $display("[FAILED] %s with %0d errors", cur_test, errors - errors_at_start);
      end
   endtask

   initial begin
      axi_resetn    = 1'b0;
      s_axis_tdata  = '0;
      s_axis_tstrb  = '0;
      s_axis_tuser  = '0;
      s_axis_tlast  = 1'b0;
      s_axis_tvalid = 1'b0;
      m_axis_tready = '1;
      last_queue    = 32'd4;
      clear_drops   = 1'b0;
      rot_ptr       = 0;
      for (int q = 0; q < NUM_QUEUES; q++) begin
         ts_seen[q]     = 1'b0;
         last_ts[q]     = '0;
         model_drops[q] = 0;
      end
      begin_test("reset");
      repeat (5) @(negedge axi_aclk);
      axi_resetn = 1'b1;
      @(negedge axi_aclk);
      compare_value("s_axis_tready after reset", 1, s_axis_tready);
      compare_value("m_axis_tvalid after reset", 0, m_axis_tvalid);
      for (int q = 0; q < NUM_QUEUES; q++) begin
         compare_value($sformatf("drop count of queue %0d after reset", q), 0,
                       drop_counts[q*32 +: 32]);
      end
      end_test();

      begin_test("rotation without drops");
      send_burst(40);
      wait_idle();
      settle_queues();
      check_clean_run();
      end_test();

      begin_test("metadata");   // Timestamps and tuser are checked on every packet
      send_burst(25);
      wait_idle();
      settle_queues();
      check_clean_run();
      end_test();

      begin_test("short rotation");
      last_queue = 32'd1;
      send_burst(30);
      wait_idle();
      settle_queues();
      check_clean_run();
      for (int q = 2; q < NUM_QUEUES; q++) begin
         compare_value($sformatf("tvalid seen on queue %0d", q), 0, valid_seen[q]);
      end
      last_queue = 32'd4;
      end_test();

      begin_test("back-pressure drops");
      pressure_run(100);
      end_test();

      begin_test("drop counter clear");
      clear_drops = 1'b1;
      @(negedge axi_aclk);
      clear_drops = 1'b0;
      for (int q = 0; q < NUM_QUEUES; q++) begin
         compare_value($sformatf("drop count of queue %0d after clear", q), 0,
                       drop_counts[q*32 +: 32]);
         model_drops[q] = 0;
      end
      pressure_run(100);
      end_test();

      $display("Summary: %0d tests ok, %0d tests failed, %0d check errors",
               tests_ok, tests_bad, errors);
      if (tests_bad == 0 && errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
